/* verilog/rs_pkg.sv */
`default_nettype none

package rs_pkg;

   localparam int PRF_ID_W = 6;
   localparam int TAG_W    = 4;

   typedef logic [PRF_ID_W-1:0] t_prf_id;
   typedef logic [TAG_W-1:0]    t_uop_tag;

   typedef enum logic {
      OP_REG = 1'b0,
      OP_IMM = 1'b1
   } t_optype;

   // One source operand as seen at dispatch
   typedef struct packed {
      logic    pend;   // Producer not yet written back
      t_prf_id psrc;
      t_optype optype;
   } t_src_descr;

endpackage

`default_nettype wire

/* verilog/rs_reg_trk.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_reg_trk
   import rs_pkg::*;
#(
   parameter int NUM_WB = 2
) (
   input  logic       clk,
   input  logic       reset,

   input  logic       alloc,
   input  t_src_descr alloc_src,
   input  logic       dealloc,

   input  logic       wb_en   [NUM_WB],
   input  t_prf_id    wb_pdst [NUM_WB],

   output t_prf_id    psrc,
   output logic       ready
);

   typedef enum logic [1:0] {
      SRC_IDLE,
      SRC_PEND,
      SRC_READY
   } t_fsm;

   t_fsm    fsm;
   t_fsm    fsm_nxt;
   t_prf_id cmp_psrc;
   logic    wb_match;

   // Allocation cycle compares against the incoming id
   assign cmp_psrc = alloc ? alloc_src.psrc : psrc;

   always_comb begin
      wb_match = 1'b0;
      for (int p = 0; p < NUM_WB; p++) begin
         if (wb_en[p] && (wb_pdst[p] == cmp_psrc)) begin
            wb_match = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         psrc <= alloc_src.psrc;
      end
   end

   always_comb begin
      fsm_nxt = fsm;
      case (fsm)
         SRC_IDLE: begin
            if (alloc) begin
               fsm_nxt = (!alloc_src.pend || wb_match) ? SRC_READY : SRC_PEND;
            end
         end
         SRC_PEND: begin
            if (wb_match) begin
               fsm_nxt = SRC_READY;
            end else if (dealloc) begin
               fsm_nxt = SRC_IDLE;
            end
         end
         SRC_READY: begin
            if (dealloc) begin
               fsm_nxt = SRC_IDLE;
            end
         end
         default: fsm_nxt = SRC_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fsm <= SRC_IDLE;
      end else begin
         fsm <= fsm_nxt;
      end
   end

   assign ready = (fsm == SRC_READY);

   // Immediates reach here with pend already cleared by rs_alloc
   a_pend_is_reg: assert property (@(posedge clk) disable iff (reset)
      (alloc && alloc_src.pend) |-> (alloc_src.optype == OP_REG));

endmodule

`default_nettype wire

/* verilog/rs_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_entry
   import rs_pkg::*;
#(
   parameter int NUM_WB = 2
) (
   input  logic       clk,
   input  logic       reset,

   input  logic       alloc,
   input  logic       dealloc,
   input  t_uop_tag   disp_tag,
   input  t_prf_id    disp_pdst,
   input  t_src_descr disp_src0,
   input  t_src_descr disp_src1,

   input  logic       wb_en   [NUM_WB],
   input  t_prf_id    wb_pdst [NUM_WB],

   output logic       valid,
   output logic       ready,
   output t_uop_tag   tag,
   output t_prf_id    pdst,
   output t_prf_id    psrc0,
   output t_prf_id    psrc1
);

   logic src0_ready;
   logic src1_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid <= 1'b0;
      end else if (alloc) begin
         valid <= 1'b1;
      end else if (dealloc) begin
         valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         tag  <= disp_tag;
         pdst <= disp_pdst;
      end
   end

   rs_reg_trk #(.NUM_WB(NUM_WB)) trk_src0 (
      .clk       (clk),
      .reset     (reset),
      .alloc     (alloc),
      .alloc_src (disp_src0),
      .dealloc   (dealloc),
      .wb_en     (wb_en),
      .wb_pdst   (wb_pdst),
      .psrc      (psrc0),
      .ready     (src0_ready)
   );

   rs_reg_trk #(.NUM_WB(NUM_WB)) trk_src1 (
      .clk       (clk),
      .reset     (reset),
      .alloc     (alloc),
      .alloc_src (disp_src1),
      .dealloc   (dealloc),
      .wb_en     (wb_en),
      .wb_pdst   (wb_pdst),
      .psrc      (psrc1),
      .ready     (src1_ready)
   );

   assign ready = valid && src0_ready && src1_ready;

   a_alloc_dealloc: assert property (@(posedge clk) disable iff (reset)
      !(alloc && dealloc));

   // Allocator must only target free slots
   a_alloc_free: assert property (@(posedge clk) disable iff (reset)
      alloc |-> !valid);

endmodule

`default_nettype wire

/* verilog/rs_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_alloc
   import rs_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
) (
   input  logic                   clk,
   input  logic                   reset,

   input  logic                   disp_valid,
   input  t_uop_tag               disp_tag,
   input  t_prf_id                disp_pdst,
   input  t_src_descr             disp_src0,
   input  t_src_descr             disp_src1,
   input  logic [NUM_ENTRIES-1:0] entry_valid,

   output logic [NUM_ENTRIES-1:0] alloc,
   output t_uop_tag               alloc_tag,
   output t_prf_id                alloc_pdst,
   output t_src_descr             alloc_src0,
   output t_src_descr             alloc_src1,
   output logic                   rs_full
);

   logic [NUM_ENTRIES-1:0] free_onehot;

   always_comb begin
      free_onehot = '0;
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin  // Last write wins, lowest index
         if (!entry_valid[i]) begin
            free_onehot    = '0;
            free_onehot[i] = 1'b1;
         end
      end
   end

   assign rs_full = &entry_valid;
   assign alloc   = (disp_valid && !rs_full) ? free_onehot : '0;

   assign alloc_tag  = disp_tag;
   assign alloc_pdst = disp_pdst;

   // Immediate operands never wait on a write-back
   always_comb begin
      alloc_src0 = disp_src0;
      alloc_src1 = disp_src1;
      if (disp_src0.optype == OP_IMM) alloc_src0.pend = 1'b0;
      if (disp_src1.optype == OP_IMM) alloc_src1.pend = 1'b0;
   end

   a_disp_full: assert property (@(posedge clk) disable iff (reset)
      !(disp_valid && rs_full))
      else $warning("dispatch dropped while window full");

   a_alloc_onehot: assert property (@(posedge clk) disable iff (reset)
      $onehot0(alloc));

endmodule

`default_nettype wire

/* verilog/rs_picker.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_picker
   import rs_pkg::*;
#(
   parameter int NUM_ENTRIES = 4
) (
   input  logic [NUM_ENTRIES-1:0] ready,
   input  logic                   issue_stall,
   input  t_uop_tag               entry_tag   [NUM_ENTRIES],
   input  t_prf_id                entry_pdst  [NUM_ENTRIES],
   input  t_prf_id                entry_psrc0 [NUM_ENTRIES],
   input  t_prf_id                entry_psrc1 [NUM_ENTRIES],

   output logic [NUM_ENTRIES-1:0] pick,
   output logic                   pick_valid,
   output t_uop_tag               pick_tag,
   output t_prf_id                pick_pdst,
   output t_prf_id                pick_psrc0,
   output t_prf_id                pick_psrc1
);

   always_comb begin
      pick = '0;
      if (!issue_stall) begin
         for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin  // Lowest ready index wins
            if (ready[i]) begin
               pick    = '0;
               pick[i] = 1'b1;
            end
         end
      end
   end

   assign pick_valid = |pick;

   // AND-OR mux, relies on pick being one-hot
   always_comb begin
      pick_tag   = '0;
      pick_pdst  = '0;
      pick_psrc0 = '0;
      pick_psrc1 = '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (pick[i]) begin
            pick_tag   = pick_tag | entry_tag[i];
            pick_pdst  = pick_pdst | entry_pdst[i];
            pick_psrc0 = pick_psrc0 | entry_psrc0[i];
            pick_psrc1 = pick_psrc1 | entry_psrc1[i];
         end
      end
   end

   always_comb begin
      a_pick_onehot: assert ($onehot0(pick));
   end

endmodule

`default_nettype wire

/* verilog/rs_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_issue
   import rs_pkg::*;
(
   input  logic     clk,
   input  logic     reset,

   input  logic     pick_valid,
   input  t_uop_tag pick_tag,
   input  t_prf_id  pick_pdst,
   input  t_prf_id  pick_psrc0,
   input  t_prf_id  pick_psrc1,

   output logic     issue_valid,
   output t_uop_tag issue_tag,
   output t_prf_id  issue_pdst,
   output t_prf_id  issue_psrc0,
   output t_prf_id  issue_psrc1
);

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= pick_valid;  // One pulse per pick
      end
   end

   always_ff @(posedge clk) begin
      issue_tag   <= pick_tag;
      issue_pdst  <= pick_pdst;
      issue_psrc0 <= pick_psrc0;
      issue_psrc1 <= pick_psrc1;
   end

endmodule

`default_nettype wire

/* verilog/rs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_top
   import rs_pkg::*;
#(
   parameter int NUM_ENTRIES = 4,
   parameter int NUM_WB      = 2
) (
   input  logic       clk,
   input  logic       reset,

   input  logic       disp_valid,
   input  t_uop_tag   disp_tag,
   input  t_prf_id    disp_pdst,
   input  t_src_descr disp_src0,
   input  t_src_descr disp_src1,
   output logic       rs_full,

   input  logic       wb_en   [NUM_WB],
   input  t_prf_id    wb_pdst [NUM_WB],

   input  logic       issue_stall,
   output logic       issue_valid,
   output t_uop_tag   issue_tag,
   output t_prf_id    issue_pdst,
   output t_prf_id    issue_psrc0,
   output t_prf_id    issue_psrc1
);

   logic [NUM_ENTRIES-1:0] alloc;
   logic [NUM_ENTRIES-1:0] pick;
   logic [NUM_ENTRIES-1:0] entry_valid;
   logic [NUM_ENTRIES-1:0] entry_ready;

   t_uop_tag   alloc_tag;
   t_prf_id    alloc_pdst;
   t_src_descr alloc_src0;
   t_src_descr alloc_src1;

   t_uop_tag entry_tag   [NUM_ENTRIES];
   t_prf_id  entry_pdst  [NUM_ENTRIES];
   t_prf_id  entry_psrc0 [NUM_ENTRIES];
   t_prf_id  entry_psrc1 [NUM_ENTRIES];

   logic     pick_valid;
   t_uop_tag pick_tag;
   t_prf_id  pick_pdst;
   t_prf_id  pick_psrc0;
   t_prf_id  pick_psrc1;

   rs_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) alloc0 (
      .clk         (clk),
      .reset       (reset),
      .disp_valid  (disp_valid),
      .disp_tag    (disp_tag),
      .disp_pdst   (disp_pdst),
      .disp_src0   (disp_src0),
      .disp_src1   (disp_src1),
      .entry_valid (entry_valid),
      .alloc       (alloc),
      .alloc_tag   (alloc_tag),
      .alloc_pdst  (alloc_pdst),
      .alloc_src0  (alloc_src0),
      .alloc_src1  (alloc_src1),
      .rs_full     (rs_full)
   );

   for (genvar e = 0; e < NUM_ENTRIES; e++) begin : g_entry
      rs_entry #(.NUM_WB(NUM_WB)) entry0 (
         .clk       (clk),
         .reset     (reset),
         .alloc     (alloc[e]),
         .dealloc   (pick[e]),  // Freed at the pick edge
         .disp_tag  (alloc_tag),
         .disp_pdst (alloc_pdst),
         .disp_src0 (alloc_src0),
         .disp_src1 (alloc_src1),
         .wb_en     (wb_en),
         .wb_pdst   (wb_pdst),
         .valid     (entry_valid[e]),
         .ready     (entry_ready[e]),
         .tag       (entry_tag[e]),
         .pdst      (entry_pdst[e]),
         .psrc0     (entry_psrc0[e]),
         .psrc1     (entry_psrc1[e])
      );
   end

   rs_picker #(.NUM_ENTRIES(NUM_ENTRIES)) picker0 (
      .ready       (entry_ready),
      .issue_stall (issue_stall),
      .entry_tag   (entry_tag),
      .entry_pdst  (entry_pdst),
      .entry_psrc0 (entry_psrc0),
      .entry_psrc1 (entry_psrc1),
      .pick        (pick),
      .pick_valid  (pick_valid),
      .pick_tag    (pick_tag),
      .pick_pdst   (pick_pdst),
      .pick_psrc0  (pick_psrc0),
      .pick_psrc1  (pick_psrc1)
   );

   rs_issue issue0 (
      .clk         (clk),
      .reset       (reset),
      .pick_valid  (pick_valid),
      .pick_tag    (pick_tag),
      .pick_pdst   (pick_pdst),
      .pick_psrc0  (pick_psrc0),
      .pick_psrc1  (pick_psrc1),
      .issue_valid (issue_valid),
      .issue_tag   (issue_tag),
      .issue_pdst  (issue_pdst),
      .issue_psrc0 (issue_psrc0),
      .issue_psrc1 (issue_psrc1)
   );

endmodule

`default_nettype wire

/* verif/rs_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_tb
   import rs_pkg::*;
();

   localparam int NUM_ENTRIES  = 4;
   localparam int NUM_WB       = 2;
   localparam int CYCLE_LIMIT  = 3000;
   localparam int RAND_CYCLES  = 1200;
   localparam int DRAIN_CYCLES = 20;
   localparam logic [31:0] SEED = 32'h22ea;

   logic       clk;
   logic       reset;
   logic       disp_valid;
   t_uop_tag   disp_tag;
   t_prf_id    disp_pdst;
   t_src_descr disp_src0;
   t_src_descr disp_src1;
   logic       rs_full;
   logic       wb_en   [NUM_WB];
   t_prf_id    wb_pdst [NUM_WB];
   logic       issue_stall;
   logic       issue_valid;
   t_uop_tag   issue_tag;
   t_prf_id    issue_pdst;
   t_prf_id    issue_psrc0;
   t_prf_id    issue_psrc1;

   int          errors;
   int          checks;
   int          cycle_cnt;
   int          dispatched;
   int          issued;
   logic [31:0] lcg_state;

   // Reference model with one slot per entry
   logic     m_valid [NUM_ENTRIES];
   t_uop_tag m_tag   [NUM_ENTRIES];
   t_prf_id  m_pdst  [NUM_ENTRIES];
   t_prf_id  m_src0  [NUM_ENTRIES];
   t_prf_id  m_src1  [NUM_ENTRIES];
   logic     m_need0 [NUM_ENTRIES];
   logic     m_need1 [NUM_ENTRIES];
   logic     written [64];  // Register ids whose value is available
   logic     exp_valid;
   t_uop_tag exp_tag;
   t_prf_id  exp_pdst;
   t_prf_id  exp_psrc0;
   t_prf_id  exp_psrc1;

   rs_top #(.NUM_ENTRIES(NUM_ENTRIES), .NUM_WB(NUM_WB)) dut0 (
      .clk         (clk),
      .reset       (reset),
      .disp_valid  (disp_valid),
      .disp_tag    (disp_tag),
      .disp_pdst   (disp_pdst),
      .disp_src0   (disp_src0),
      .disp_src1   (disp_src1),
      .rs_full     (rs_full),
      .wb_en       (wb_en),
      .wb_pdst     (wb_pdst),
      .issue_stall (issue_stall),
      .issue_valid (issue_valid),
      .issue_tag   (issue_tag),
      .issue_pdst  (issue_pdst),
      .issue_psrc0 (issue_psrc0),
      .issue_psrc1 (issue_psrc1)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int unsigned rand_below(int unsigned n);
      return (lcg_next() >> 16) % n;  // Upper bits are the better ones
   endfunction

   function automatic t_src_descr reg_src(logic pend, t_prf_id id);
      t_src_descr s;
      s.pend   = pend;
      s.psrc   = id;
      s.optype = OP_REG;
      return s;
   endfunction

   function automatic t_src_descr imm_src(t_prf_id id);
      t_src_descr s;
      s.pend   = 1'b1;  // Must be ignored for immediates
      s.psrc   = id;
      s.optype = OP_IMM;
      return s;
   endfunction

   task automatic tick();
      @(negedge clk);
   endtask

   task automatic clear_inputs();
      disp_valid  = 1'b0;
      disp_tag    = '0;
      disp_pdst   = '0;
      disp_src0   = '0;
      disp_src1   = '0;
      issue_stall = 1'b0;
      for (int p = 0; p < NUM_WB; p++) begin
         wb_en[p]   = 1'b0;
         wb_pdst[p] = '0;
      end
   endtask

   task automatic dispatch(t_uop_tag tag, t_prf_id pdst, t_src_descr s0, t_src_descr s1);
      disp_valid = 1'b1;
      disp_tag   = tag;
      disp_pdst  = pdst;
      disp_src0  = s0;
      disp_src1  = s1;
   endtask

   task automatic check_idle(string msg);
      checks++;
      assert (!issue_valid) else begin
         errors++;
         $display("Mismatch at %0t: %s, unexpected issue of tag %0d", $time, msg, issue_tag);
      end
   endtask

   task automatic check_issue(t_uop_tag tag, t_prf_id pdst, t_prf_id ps0, t_prf_id ps1,
                              string msg);
      checks++;
      assert (issue_valid && issue_tag == tag && issue_pdst == pdst &&
              issue_psrc0 == ps0 && issue_psrc1 == ps1) else begin
         errors++;
         $display("Mismatch at %0t: %s, got valid %0b tag %0d pdst %0d src %0d/%0d", $time,
                  msg, issue_valid, issue_tag, issue_pdst, issue_psrc0, issue_psrc1);
         $display("   expected tag %0d pdst %0d src %0d/%0d", tag, pdst, ps0, ps1);
      end
   endtask

   task automatic check_full(logic exp, string msg);
      checks++;
      assert (rs_full == exp) else begin
         errors++;
         $display("Mismatch at %0t: %s, rs_full %0b expected %0b", $time, msg, rs_full, exp);
      end
   endtask

   // Inputs are set up; the pulse comes on the second falling edge
   task automatic expect_pulse(t_uop_tag tag, t_prf_id pdst, t_prf_id ps0, t_prf_id ps1,
                               string msg);
      tick();
      clear_inputs();
      check_idle({msg, ", one cycle in"});
      tick();
      check_issue(tag, pdst, ps0, ps1, msg);
      tick();
      check_idle({msg, ", after the pulse"});
   endtask

   task automatic test_reset();
      check_idle("after reset");
      check_full(1'b0, "after reset");
   endtask

   task automatic test_ready_dispatch();
      dispatch(4'd1, 6'd5, reg_src(1'b0, 6'd1), reg_src(1'b0, 6'd2));
      expect_pulse(4'd1, 6'd5, 6'd1, 6'd2, "ready register sources");
      dispatch(4'd2, 6'd6, imm_src(6'd9), reg_src(1'b0, 6'd3));
      expect_pulse(4'd2, 6'd6, 6'd9, 6'd3, "immediate source");
   endtask

   task automatic test_wakeup();
      dispatch(4'd3, 6'd7, reg_src(1'b1, 6'd10), reg_src(1'b0, 6'd4));
      tick();
      clear_inputs();
      repeat (4) begin
         wb_en[0]   = 1'b1;
         wb_pdst[0] = 6'd11;
         wb_en[1]   = 1'b1;
         wb_pdst[1] = 6'd12;
         tick();
         check_idle("pending source, other write-backs");
      end
      wb_en[0]   = 1'b0;
      wb_pdst[1] = 6'd10;
      expect_pulse(4'd3, 6'd7, 6'd10, 6'd4, "wake on port 1");

      dispatch(4'd4, 6'd8, reg_src(1'b0, 6'd4), reg_src(1'b1, 6'd13));
      tick();
      clear_inputs();
      tick();
      check_idle("pending source, no write-back");
      wb_en[0]   = 1'b1;
      wb_pdst[0] = 6'd13;
      expect_pulse(4'd4, 6'd8, 6'd4, 6'd13, "wake on port 0");

      dispatch(4'd5, 6'd9, reg_src(1'b1, 6'd20), reg_src(1'b1, 6'd21));
      wb_en[0]   = 1'b1;
      wb_pdst[0] = 6'd20;
      wb_en[1]   = 1'b1;
      wb_pdst[1] = 6'd21;
      expect_pulse(4'd5, 6'd9, 6'd20, 6'd21, "wake in dispatch cycle");
   endtask

   task automatic test_full();
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         dispatch(t_uop_tag'(i + 1), t_prf_id'(40 + i), reg_src(1'b1, 6'd30),
                  reg_src(1'b0, t_prf_id'(i)));
         tick();
         clear_inputs();
         check_idle("filling window");
      end
      check_full(1'b1, "four entries held");
      dispatch(4'd9, 6'd50, reg_src(1'b0, 6'd1), reg_src(1'b0, 6'd2));  // Would issue if stored
      tick();
      clear_inputs();
      check_idle("dispatch while full");
      tick();
      check_idle("dispatch while full");
      wb_en[0]   = 1'b1;
      wb_pdst[0] = 6'd30;
      tick();
      clear_inputs();
      check_idle("shared source written back");
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         tick();
         check_issue(t_uop_tag'(i + 1), t_prf_id'(40 + i), 6'd30, t_prf_id'(i), "entry order");
      end
      tick();
      check_idle("dropped dispatch");
      check_full(1'b0, "window drained");
   endtask

   task automatic test_stall();
      issue_stall = 1'b1;
      dispatch(4'd6, 6'd51, reg_src(1'b0, 6'd1), reg_src(1'b0, 6'd2));
      tick();
      dispatch(4'd7, 6'd52, reg_src(1'b0, 6'd3), imm_src(6'd4));
      tick();
      disp_valid = 1'b0;
      check_idle("stalled");
      repeat (4) begin
         tick();
         check_idle("stalled");
      end
      issue_stall = 1'b0;
      tick();
      check_issue(4'd6, 6'd51, 6'd1, 6'd2, "first after stall");
      tick();
      check_issue(4'd7, 6'd52, 6'd3, 6'd4, "second after stall");
      tick();
      check_idle("after stall release");
   endtask

   // Advances the model across the coming rising edge
   task automatic update_model();
      int pick;
      int slot;
      pick = -1;
      slot = -1;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         if (pick < 0 && !issue_stall && m_valid[i] && !m_need0[i] && !m_need1[i]) begin
            pick = i;
         end
         if (slot < 0 && !m_valid[i]) begin
            slot = i;
         end
      end
      exp_valid = (pick >= 0);
      if (pick >= 0) begin
         exp_tag        = m_tag[pick];
         exp_pdst       = m_pdst[pick];
         exp_psrc0      = m_src0[pick];
         exp_psrc1      = m_src1[pick];
         m_valid[pick]  = 1'b0;
      end
      if (disp_valid && slot >= 0) begin
         m_valid[slot] = 1'b1;
         m_tag[slot]   = disp_tag;
         m_pdst[slot]  = disp_pdst;
         m_src0[slot]  = disp_src0.psrc;
         m_src1[slot]  = disp_src1.psrc;
         m_need0[slot] = disp_src0.pend && (disp_src0.optype == OP_REG);
         m_need1[slot] = disp_src1.pend && (disp_src1.optype == OP_REG);
         written[disp_pdst] = 1'b0;  // New producer for this id
         dispatched++;
      end
      for (int p = 0; p < NUM_WB; p++) begin
         if (wb_en[p]) begin
            written[wb_pdst[p]] = 1'b1;
            for (int i = 0; i < NUM_ENTRIES; i++) begin
               if (m_valid[i] && m_src0[i] == wb_pdst[p]) begin
                  m_need0[i] = 1'b0;
               end
               if (m_valid[i] && m_src1[i] == wb_pdst[p]) begin
                  m_need1[i] = 1'b0;
               end
            end
         end
      end
   endtask

   task automatic compare_issue(string msg);
      if (exp_valid) begin
         check_issue(exp_tag, exp_pdst, exp_psrc0, exp_psrc1, msg);
      end else begin
         check_idle(msg);
      end
      if (issue_valid) begin
         issued++;
      end
   endtask

   task automatic test_random();
      logic       full;
      logic       drain;
      t_prf_id    id;
      t_src_descr src [2];
      exp_valid  = 1'b0;
      dispatched = 0;
      issued     = 0;
      for (int i = 0; i < 64; i++) begin
         written[i] = 1'b1;
      end
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         m_valid[i] = 1'b0;
      end
      for (int cyc = 0; cyc < RAND_CYCLES + DRAIN_CYCLES; cyc++) begin
         drain = (cyc >= RAND_CYCLES);  // Drain sweeps every id without stall
         compare_issue("random mix");
         full = 1'b1;
         for (int i = 0; i < NUM_ENTRIES; i++) begin
            full = full && m_valid[i];
         end
         check_full(full, "random mix");
         clear_inputs();
         issue_stall = !drain && (rand_below(4) == 0);
         for (int p = 0; p < NUM_WB; p++) begin
            wb_en[p]   = drain || (rand_below(2) == 0);
            wb_pdst[p] = drain ? t_prf_id'((2 * cyc + p) % 16) : t_prf_id'(rand_below(16));
         end
         if (!drain && !full && rand_below(3) != 0) begin
            for (int s = 0; s < 2; s++) begin
               id     = t_prf_id'(rand_below(16));
               src[s] = (rand_below(4) == 0) ? imm_src(id) : reg_src(!written[id], id);
            end
            dispatch(t_uop_tag'(dispatched % 16), t_prf_id'(rand_below(16)), src[0], src[1]);
         end
         update_model();
         tick();
      end
      clear_inputs();
      compare_issue("random drain");
      checks++;
      assert (issued == dispatched) else begin
         errors++;
         $display("Mismatch at %0t: %0d micro-ops issued, %0d dispatched", $time, issued,
                  dispatched);
      end
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run still going after %0d cycles", cycle_cnt);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      errors    = 0;
      checks    = 0;
      lcg_state = SEED;
      reset     = 1'b1;
      clear_inputs();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      tick();
      test_reset();
      test_ready_dispatch();
      test_wakeup();
      test_full();
      test_stall();
      test_random();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
verilog/rs_pkg.sv
verilog/rs_reg_trk.sv
verilog/rs_entry.sv
verilog/rs_alloc.sv
verilog/rs_picker.sv
verilog/rs_issue.sv
verilog/rs_top.sv
verif/rs_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps --top-module rs_tb -f list.f

out=$(./obj_dir/Vrs_tb) || true
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
   exit 0
fi
exit 1
